// File: verilog/pipeCtrl_params.svh
// Width, latency and run-length macros shared by the pipeline control design
// and its testbench
`ifndef PIPECTRL_PARAMS_SVH
`define PIPECTRL_PARAMS_SVH

////////////////////
// Widths
////////////////////

// Bits in a program index, which also bounds the program length
`define PC_W 10

// Bits in a register number
`define REG_W 5

////////////////////
// Timing
////////////////////

// Extra cycles that a divide holds the Execute stage
`define DIV_CYCLES 4

// Program instructions run by the testbench, unused by the RTL
`define RUN_LENGTH 400

`endif

// File: verilog/pipeTypes.sv
// Package with the index and register typedefs, the instruction kind enum
// and the packed structs that travel between the pipeline blocks
`default_nettype none
`include "pipeCtrl_params.svh"

package pipeTypesPkg;

  // Program index, one step per instruction
  typedef logic [`PC_W-1:0] pcT;

  // Architectural register number, register 0 never carries a dependency
  typedef logic [`REG_W-1:0] regT;

  // What an instruction does to the control flow
  // Only loads, divides, wrong branches, CSR writes and traps
  // change the flow of the pipeline, every other kind is an ALU op
  typedef enum logic [2:0] {
    kAlu,
    kLoad,
    kDiv,
    kBranchWrong,
    kCsrWrite,
    kTrap
  } kindT;

  // Instruction descriptor, one 24-bit word
  // A descriptor with valid low is a bubble
  typedef struct packed {
    logic valid;
    pcT   pc;
    kindT kind;
    regT  rd;
    regT  rs1;
  } instrT;

  // Request to restart fetch at target
  typedef struct packed {
    logic valid;
    pcT   target;
  } redirectT;

  // One stall level per stage, Fetch first
  typedef struct packed {
    logic f;
    logic d;
    logic e;
    logic m;
    logic w;
  } stallT;

  // One flush strobe per stage after Fetch
  typedef struct packed {
    logic d;
    logic e;
    logic m;
    logic w;
  } flushT;

endpackage

`default_nettype wire

// File: verilog/fetchUnit.sv
// Fetch unit with the program counter, the Fetch stage register and
// redirect handling
`timescale 1ns/100ps
`default_nettype none

module fetchUnit (
  input  logic                   clk,
  input  logic                   reset,
  input  pipeTypesPkg::stallT    stall,
  input  pipeTypesPkg::flushT    flush,
  input  pipeTypesPkg::redirectT redirect,
  input  pipeTypesPkg::instrT    imemInstr,
  output pipeTypesPkg::pcT       fetchPc,
  output pipeTypesPkg::instrT    instrF
);

  import pipeTypesPkg::*;

  // Empty descriptor loaded in place of a squashed fetch
  localparam instrT Bubble = '0;

  ////////////////////
  // Program counter
  ////////////////////

  // A redirect wins over the sequential step
  // While the pipeline is stalled the redirect keeps reloading the same
  // target, since the instruction that raised it is held as well
  // Without a redirect the PC only steps when Fetch is free to move
  always_ff @(posedge clk) begin
    if (reset) begin
      fetchPc <= '0;
    end else if (redirect.valid) begin
      fetchPc <= redirect.target;
    end else if (!stall.f) begin
      fetchPc <= fetchPc + 1'b1;
    end
  end

  ////////////////////
  // Fetch register
  ////////////////////

  // The memory answers for the current PC within the cycle
  // On a Decode flush the word in flight belongs to the wrong path, so a
  // bubble is captured and Decode never sees it
  always_ff @(posedge clk) begin
    if (reset) begin
      instrF.valid <= 1'b0;
    end else if (!stall.f) begin
      instrF <= flush.d ? Bubble : imemInstr;
    end
  end

  // The PC may only move under a stall when a redirect forces it
  pcHoldOnStall: assert property (@(posedge clk) disable iff (reset)
    stall.f && !redirect.valid |=> $stable(fetchPc))
    else $error("PC moved while Fetch was stalled");

  // Every redirect must come with a Decode flush, otherwise the wrong-path
  // word captured here would reach Decode
  redirectFlushesDecode: assert property (@(posedge clk) disable iff (reset)
    redirect.valid |-> flush.d)
    else $error("Redirect without a Decode flush");

endmodule

`default_nettype wire

// File: verilog/hazard.sv
// Combinational stall and flush unit for the five-stage pipeline
`timescale 1ns/100ps
`default_nettype none

module hazard (
  input  logic                bpWrongE,
  input  logic                csrWriteFenceM,
  input  logic                trapM,
  input  logic                loadUseStallD,
  input  logic                divBusyE,
  input  logic                lsuStallM,
  input  logic                ifuStallF,
  input  logic                externalStall,
  output pipeTypesPkg::stallT stall,
  output pipeTypesPkg::flushT flush
);

  logic flushDCause, flushECause, flushMCause, flushWCause;
  logic stallDCause, stallECause, stallWCause;
  logic stallF, stallD, stallE, stallM, stallW;
  logic latestUnstalledE, latestUnstalledM;

  ////////////////////
  // Flush causes
  ////////////////////

  // A trap kills everything behind it, itself included on its way into W
  // A CSR write retires but everything younger is refetched
  // A wrong branch kills the two younger instructions, but a divide still
  // busy in Execute must not be thrown away
  assign flushDCause = trapM | csrWriteFenceM | bpWrongE;
  assign flushECause = trapM | csrWriteFenceM | (bpWrongE & ~divBusyE);
  assign flushMCause = trapM | csrWriteFenceM;
  assign flushWCause = trapM;

  ////////////////////
  // Stall causes
  ////////////////////

  // A flush beats a stall in the same stage, so each cause is gated here
  // Instruction and data memory waits freeze the whole pipeline
  // An instruction memory wait is moot when Decode is being flushed anyway
  assign stallDCause = loadUseStallD & ~flushDCause;
  assign stallECause = divBusyE & ~flushECause;
  assign stallWCause = (ifuStallF & ~flushDCause) | (lsuStallM & ~flushWCause) |
                       externalStall;

  // A stage stalls for its own cause or when the stage after it stalls
  // Fetch and Memory have no causes of their own
  assign stallW = stallWCause;
  assign stallM = stallW;
  assign stallE = stallECause | stallM;
  assign stallD = stallDCause | stallE;
  assign stallF = stallD;

  // The first stage behind a stalled one takes a bubble
  // Decode and Writeback can never be in that position since Fetch and
  // Memory always stall together with their successor
  assign latestUnstalledE = ~stallE & stallD;
  assign latestUnstalledM = ~stallM & stallE;

  assign stall = '{f: stallF, d: stallD, e: stallE, m: stallM, w: stallW};
  assign flush = '{d: flushDCause,
                   e: latestUnstalledE | flushECause,
                   m: latestUnstalledM | flushMCause,
                   w: flushWCause};

endmodule

`default_nettype wire

// File: verilog/pipeStages.sv
// Decode, Execute, Memory and Writeback stage registers with the load-use
// detector, the divide busy counter and the redirect selection
`timescale 1ns/100ps
`default_nettype none
`include "pipeCtrl_params.svh"

module pipeStages (
  input  logic                   clk,
  input  logic                   reset,
  input  pipeTypesPkg::instrT    instrF,
  input  pipeTypesPkg::stallT    stall,
  input  pipeTypesPkg::flushT    flush,
  input  logic                   dmemStall,
  output logic                   bpWrongE,
  output logic                   csrWriteFenceM,
  output logic                   trapM,
  output logic                   loadUseStallD,
  output logic                   divBusyE,
  output logic                   lsuStallM,
  output pipeTypesPkg::redirectT redirect,
  output pipeTypesPkg::instrT    instrW
);

  import pipeTypesPkg::*;

  // Counter wide enough to hold the full divide latency
  localparam int DivCountW = $clog2(`DIV_CYCLES + 1);
  localparam logic [DivCountW-1:0] DivCycles = DivCountW'(`DIV_CYCLES);

  localparam instrT Bubble = '0;

  instrT                instrD, instrE, instrM;
  logic [DivCountW-1:0] divCount;
  logic                 divEntersE;

  ////////////////////
  // Stage registers
  ////////////////////

  // Each register moves when its stage is not stalled and takes a bubble
  // when its stage flushes
  // A flush raised under a stall waits here, which is safe because the
  // instruction that raised it is held in place as well
  always_ff @(posedge clk) begin
    if (reset) begin
      instrD.valid <= 1'b0;
      instrE.valid <= 1'b0;
      instrM.valid <= 1'b0;
      instrW.valid <= 1'b0;
    end else begin
      if (!stall.d) begin
        instrD <= flush.d ? Bubble : instrF;
      end
      if (!stall.e) begin
        instrE <= flush.e ? Bubble : instrD;
      end
      if (!stall.m) begin
        instrM <= flush.m ? Bubble : instrE;
      end
      // A trap in Memory flushes W here, so it arrives as a bubble
      if (!stall.w) begin
        instrW <= flush.w ? Bubble : instrM;
      end
    end
  end

  ////////////////////
  // Decode hazards
  ////////////////////

  // The load result is not ready before Memory, so a consumer right behind
  // it waits one cycle while a bubble goes into Execute
  assign loadUseStallD = instrD.valid && instrE.valid && instrE.kind == kLoad &&
                         instrE.rd != '0 && instrE.rd == instrD.rs1;

  ////////////////////
  // Divider
  ////////////////////

  // A divide that really enters Execute starts the count
  assign divEntersE = !stall.e && !flush.e && instrD.valid && instrD.kind == kDiv;

  // The count keeps running under a pipeline stall and restarts with every
  // new Execute instruction, so a flushed divide leaves nothing behind
  always_ff @(posedge clk) begin
    if (reset) begin
      divCount <= '0;
    end else if (!stall.e) begin
      divCount <= divEntersE ? DivCycles : '0;
    end else if (divCount != '0) begin
      divCount <= divCount - 1'b1;
    end
  end

  assign divBusyE = instrE.valid && instrE.kind == kDiv && divCount != '0;

  ////////////////////
  // Redirect causes
  ////////////////////

  assign bpWrongE       = instrE.valid && instrE.kind == kBranchWrong;
  assign csrWriteFenceM = instrM.valid && instrM.kind == kCsrWrite;
  assign trapM          = instrM.valid && instrM.kind == kTrap;

  // Data memory waits matter only for a load sitting in Memory
  assign lsuStallM = instrM.valid && instrM.kind == kLoad && dmemStall;

  // The older instruction in Memory wins over a branch in Execute, which
  // it flushes anyway
  // Both restart at the instruction right after the one that redirects
  always_comb begin
    redirect.valid = trapM | csrWriteFenceM | bpWrongE;
    if (trapM | csrWriteFenceM) begin
      redirect.target = instrM.pc + 1'b1;
    end else begin
      redirect.target = instrE.pc + 1'b1;
    end
  end

  divCountRange: assert property (@(posedge clk) disable iff (reset)
    divCount <= DivCycles)
    else $error("Divide counter beyond its latency");

endmodule

`default_nettype wire

// File: verilog/retireUnit.sv
// Retire unit with the registered retire strobe and the retired-instruction
// counter
`timescale 1ns/100ps
`default_nettype none

module retireUnit (
  input  logic                clk,
  input  logic                reset,
  input  pipeTypesPkg::instrT instrW,
  input  logic                stallW,
  input  logic                flushW,
  output logic                retire,
  output pipeTypesPkg::instrT retireInstr,
  output logic [31:0]         instret
);

  logic retireW;

  // The instruction in Writeback completes when the stage moves on
  // A Writeback flush only empties the register behind it, so the
  // instruction already there still completes
  assign retireW = instrW.valid & ~stallW;

  // Strobe and counter go out of flops, one cycle after Writeback
  always_ff @(posedge clk) begin
    if (reset) begin
      retire  <= 1'b0;
      instret <= '0;
    end else begin
      retire <= retireW;
      if (retireW) begin
        instret <= instret + 32'd1;
      end
    end
  end

  // Holds the last retired instruction between strobes
  always_ff @(posedge clk) begin
    if (retireW) begin
      retireInstr <= instrW;
    end
  end

  // Program order on the way out
  retireInOrder: assert property (@(posedge clk) disable iff (reset)
    retireW && instret != '0 |-> instrW.pc > retireInstr.pc)
    else $error("Instruction retired out of program order");

  // A flushed Writeback must hold a bubble next, this keeps traps from retiring
  flushEmptiesW: assert property (@(posedge clk) disable iff (reset)
    flushW && !stallW |=> !instrW.valid)
    else $error("Writeback not emptied after its flush");

endmodule

`default_nettype wire

// File: verilog/pipeCtrl.sv
// Top level of the pipeline control with the fetch unit, the stage
// registers, the hazard unit and the retire unit
`timescale 1ns/100ps
`default_nettype none

module pipeCtrl (
  input  logic                clk,
  input  logic                reset,
  input  pipeTypesPkg::instrT imemInstr,
  input  logic                imemStall,
  input  logic                dmemStall,
  input  logic                externalStall,
  output pipeTypesPkg::pcT    fetchPc,
  output logic                retire,
  output pipeTypesPkg::instrT retireInstr,
  output logic [31:0]         instret,
  output pipeTypesPkg::stallT stall,
  output pipeTypesPkg::flushT flush
);

  import pipeTypesPkg::*;

  instrT    instrF, instrW;
  redirectT redirect;

  // Hazard causes from the stage registers
  logic bpWrongE, csrWriteFenceM, trapM;
  logic loadUseStallD, divBusyE, lsuStallM;

  fetchUnit i_fetch (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush),
    .redirect(redirect), .imemInstr(imemInstr),
    .fetchPc(fetchPc), .instrF(instrF)
  );

  pipeStages i_stages (
    .clk(clk), .reset(reset), .instrF(instrF), .stall(stall), .flush(flush),
    .dmemStall(dmemStall), .bpWrongE(bpWrongE), .csrWriteFenceM(csrWriteFenceM),
    .trapM(trapM), .loadUseStallD(loadUseStallD), .divBusyE(divBusyE),
    .lsuStallM(lsuStallM), .redirect(redirect), .instrW(instrW)
  );

  // Instruction memory waits arrive here as the Fetch stall cause
  hazard i_hazard (
    .bpWrongE(bpWrongE), .csrWriteFenceM(csrWriteFenceM), .trapM(trapM),
    .loadUseStallD(loadUseStallD), .divBusyE(divBusyE), .lsuStallM(lsuStallM),
    .ifuStallF(imemStall), .externalStall(externalStall),
    .stall(stall), .flush(flush)
  );

  // Retire shows up one cycle after the instruction completes in Writeback
  retireUnit i_retire (
    .clk(clk), .reset(reset), .instrW(instrW), .stallW(stall.w), .flushW(flush.w),
    .retire(retire), .retireInstr(retireInstr), .instret(instret)
  );

endmodule

`default_nettype wire

// File: test/pipeCtrlTb.sv
// Testbench for the pipeline control with the random program, memory stall
// stimulus, the in-order retirement model, the checks and the watchdog
`timescale 1ns/100ps
`default_nettype none
`include "pipeCtrl_params.svh"

module pipeCtrlTb;

  import pipeTypesPkg::*;

  localparam int ClkPeriod = 20;
  localparam int DriveDelay = 2;
  localparam int ProgLen = `RUN_LENGTH + 8;
  localparam longint TimeoutNs = longint'(`RUN_LENGTH) * 40 * ClkPeriod;

  logic  clk;
  logic  reset;
  instrT imemInstr;
  logic  imemStall, dmemStall, externalStall;
  pcT    fetchPc;
  logic  retire;
  instrT retireInstr;
  logic [31:0] instret;
  stallT stall;
  flushT flush;

  instrT       progMem [ProgLen];
  pcT          expectQ [$];
  logic [31:0] lfsrState;
  int          nonTrapCount;
  int          pulses;
  int          samplesAfterReset;
  logic        prevExternal;
  logic        done;

  pipeCtrl i_dut (
    .clk(clk), .reset(reset), .imemInstr(imemInstr), .imemStall(imemStall),
    .dmemStall(dmemStall), .externalStall(externalStall), .fetchPc(fetchPc),
    .retire(retire), .retireInstr(retireInstr), .instret(instret),
    .stall(stall), .flush(flush)
  );

  ////////////////////
  // Helpers
  ////////////////////

  // Right-shifting Galois LFSR, the mask taps a maximal-length polynomial
  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    logic [31:0] next;
    next = s >> 1;
    if (s[0]) begin
      next = next ^ 32'hA300_0000;
    end
    return next;
  endfunction

  // One LFSR step per bit, bits shifted in from the right
  task automatic drawBits(input int count, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < count; i++) begin
      lfsrState = galoisStep(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
  endtask

  task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("ERROR %0t ns: %s (got %0d, expected %0d)", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // Past the end of the program the memory answers with plain ALU ops
  function automatic instrT wordAt(input pcT pc);
    instrT word;
    word = '{valid: 1'b1, pc: pc, kind: kAlu, rd: '0, rs1: '0};
    if (int'(pc) < ProgLen) begin
      word = progMem[pc];
    end
    return word;
  endfunction

  // The first RUN_LENGTH entries are random, the tail is ALU filler so that
  // fetching ahead of the last instruction stays inside the array
  // Registers come from a small range so that load-use hazards are common
  task automatic buildProgram();
    logic [31:0] kindBits, rdBits, rsBits;
    int i;
    for (i = 0; i < ProgLen; i++) begin
      drawBits(3, kindBits);
      drawBits(2, rdBits);
      drawBits(2, rsBits);
      progMem[i] = '{valid: 1'b1, pc: pcT'(i), kind: kAlu,
                     rd: regT'(rdBits), rs1: regT'(rsBits)};
      if (i < `RUN_LENGTH) begin
        case (kindBits[2:0])
          3'd3: progMem[i].kind = kLoad;
          3'd4: progMem[i].kind = kDiv;
          3'd5: progMem[i].kind = kBranchWrong;
          3'd6: progMem[i].kind = kCsrWrite;
          3'd7: progMem[i].kind = kTrap;
          default: progMem[i].kind = kAlu;
        endcase
        // Architectural order is program order without the traps
        if (progMem[i].kind != kTrap) begin
          expectQ.push_back(pcT'(i));
          nonTrapCount++;
        end
      end
    end
  endtask

  ////////////////////
  // Clock and reset
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    imemInstr = '0;
    imemStall = 1'b0;
    dmemStall = 1'b0;
    externalStall = 1'b0;
    lfsrState = 32'hc543;
    nonTrapCount = 0;
    pulses = 0;
    samplesAfterReset = 0;
    prevExternal = 1'b0;
    done = 1'b0;
    buildProgram();
    repeat (5) @(posedge clk);
    #DriveDelay reset = 1'b0;
    wait (done);
    checkEqual(instret, nonTrapCount, "final instret against non-trap count");
    $display("TEST PASSED");
    $finish;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // The memory answers for the PC of the new cycle, each stall about 1 in 8
  always @(posedge clk) begin : driveInputs
    logic        quiet;
    logic [31:0] r;
    quiet = reset;
    #DriveDelay;
    imemInstr = wordAt(fetchPc);
    if (quiet) begin
      imemStall = 1'b0;
      dmemStall = 1'b0;
      externalStall = 1'b0;
    end else begin
      drawBits(3, r);
      imemStall = (r[2:0] == 3'b111);
      drawBits(3, r);
      dmemStall = (r[2:0] == 3'b111);
      drawBits(3, r);
      externalStall = (r[2:0] == 3'b111);
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Sampled mid-cycle, where inputs and the DUT outputs have settled
  always @(negedge clk) begin : checkOutputs
    pcT expPc;
    if (!reset) begin
      checkEqual(stall.f, stall.f | stall.d, "Fetch stall below Decode stall");
      checkEqual(stall.d, stall.d | stall.e, "Decode stall below Execute stall");
      checkEqual(stall.e, stall.e | stall.m, "Execute stall below Memory stall");
      checkEqual(stall.m, stall.m | stall.w, "Memory stall below Writeback stall");
      // The first stage behind a stalled one takes a bubble
      if (stall.d && !stall.e) begin
        checkEqual(flush.e, 1'b1, "Execute not flushed behind a stalled Decode");
      end
      if (stall.e && !stall.m) begin
        checkEqual(flush.m, 1'b1, "Memory not flushed behind a stalled Execute");
      end
      // Only a trap flushes Writeback, and a trap flushes every younger stage too
      if (flush.w) begin
        checkEqual({flush.d, flush.e, flush.m}, 3'b111,
                   "Writeback flush without the younger stages");
      end
      if (externalStall) begin
        checkEqual(stall.w, 1'b1, "Writeback not stalled under external stall");
      end
      // Retire is a flop, so an external stall shows up one cycle later
      if (prevExternal) begin
        checkEqual(retire, 1'b0, "retire pulse during external stall");
      end
      if (samplesAfterReset < 5) begin
        checkEqual(retire, 1'b0, "retire before the pipeline could fill");
      end
      if (retire) begin
        pulses++;
        checkEqual(expectQ.size() != 0, 1'b1, "retire past the end of the program");
        checkEqual(retireInstr.valid, 1'b1, "retired a bubble");
        checkEqual(retireInstr.kind == kTrap, 1'b0, "retired a trap");
        // A refetch after a branch, CSR write or trap must resume at the
        // very next instruction in program order
        expPc = expectQ.pop_front();
        checkEqual(retireInstr.pc, expPc, "retired pc out of order");
        checkEqual(retireInstr, wordAt(expPc), "retired word differs from the program");
        if (expectQ.size() == 0) begin
          done = 1'b1;
        end
      end
      checkEqual(instret, pulses, "instret against retire pulses seen");
      prevExternal = externalStall;
      samplesAfterReset++;
    end
  end

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    #(TimeoutNs);
    $display("Timeout: the run took too long and %0d instructions never retired",
             expectQ.size());
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verilog
verilog/pipeTypes.sv
verilog/fetchUnit.sv
verilog/hazard.sv
verilog/pipeStages.sv
verilog/retireUnit.sv
verilog/pipeCtrl.sv
test/pipeCtrlTb.sv
